/* common/sgd_cfg_pkg.sv */
package sgd_cfg_pkg;

    // geometry of the data path
    localparam int NUM_FEATURES  = 8;    // features per sample, weights in model
    localparam int BATCH_SIZE    = 8;    // samples per batch, labels per label line
    localparam int BATCH_BITS    = $clog2(BATCH_SIZE);
    localparam int FEATURE_W     = 16;   // features and labels
    localparam int WEIGHT_W      = 32;   // weights, dot, loss, gradient
    localparam int LINE_W        = 128;
    localparam int ADDR_W        = 58;   // cache-line address
    localparam int TAG_W         = 8;
    localparam int TAG_LABEL_BIT = TAG_W - 1;  // set on label lines
    localparam int FRAC_BITS     = 8;    // weight fraction bits

    // parameter vector, low bit of each field
    localparam int PARAM_W         = 256;
    localparam int P_ADDR_A_LO     = 0;
    localparam int P_ADDR_B_LO     = 64;
    localparam int P_ADDR_MODEL_LO = 128;
    localparam int P_STEP_LO       = 192;
    localparam int STEP_W          = 5;
    localparam int P_EPOCHS_LO     = 208;
    localparam int EPOCHS_W        = 16;
    localparam int P_SAMPLES_LO    = 224;
    localparam int SAMPLES_W       = 32;   // multiple of BATCH_SIZE

    // response FIFOs
    localparam int FIFO_DEPTH_BITS = 4;
    localparam int FIFO_SLACK      = 4;    // room for responses still in flight

endpackage

/* common/sgd_types_pkg.sv */
package sgd_types_pkg;

    // single words
    typedef logic signed [sgd_cfg_pkg::FEATURE_W-1:0] feature_t;  // labels too
    typedef logic signed [sgd_cfg_pkg::WEIGHT_W-1:0]  weight_t;

    // one host line of features, word 0 in the low bits
    typedef feature_t [sgd_cfg_pkg::NUM_FEATURES-1:0] feature_line_t;

    // labels of one batch, label i belongs to sample i
    typedef feature_t [sgd_cfg_pkg::BATCH_SIZE-1:0] label_line_t;

    // model or gradient, one word per feature
    typedef weight_t [sgd_cfg_pkg::NUM_FEATURES-1:0] weight_vec_t;

endpackage

/* common/sgd_stream_if.sv */
`timescale 1ns/1ps

// dot product -> gradient, one item per cycle, no back-pressure
interface sample_if;
    import sgd_types_pkg::*;

    logic          valid;
    feature_line_t features;
    weight_t       dot;            // already shifted by FRAC_BITS
    logic          last_in_batch;
    logic          last_of_run;    // final sample of final epoch

    modport src (output valid, features, dot, last_in_batch, last_of_run);
    modport dst (input valid, features, dot, last_in_batch, last_of_run);
endinterface

// gradient -> model, one pulse per batch
interface update_if;
    import sgd_types_pkg::*;

    logic        valid;
    weight_vec_t grad;
    logic        last_of_run;

    modport src (output valid, grad, last_of_run);
    modport dst (input valid, grad, last_of_run);
endinterface

/* source/sgd_fifo.sv */
`timescale 1ns/1ps

module sgd_fifo #(
    parameter type payload_t = logic [sgd_cfg_pkg::LINE_W-1:0]
) (
    input  logic     clk,
    input  logic     rst_n_g,
    input  logic     wr_en,
    input  payload_t din,
    output logic     almost_full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);
    import sgd_cfg_pkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

    payload_t                   mem [DEPTH];
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;   // occupancy, one bit wider than the pointers
    logic                       do_rd;

    assign do_rd       = rd_en & ~empty;  // a read on empty is dropped
    assign empty       = (count == '0);
    assign almost_full = (count >= (FIFO_DEPTH_BITS+1)'(DEPTH - FIFO_SLACK));
    assign dout        = mem[rd_ptr];      // head shown before the read

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (FIFO_DEPTH_BITS+1)'(wr_en) - (FIFO_DEPTH_BITS+1)'(do_rd);
        end
    end

endmodule

/* host/sgd_mem_rd.sv */
`timescale 1ns/1ps

module sgd_mem_rd (
    input  logic                               clk,
    input  logic                               rst_n_g,
    input  logic                               start,
    input  logic [sgd_cfg_pkg::ADDR_W-1:0]     addr_a,
    input  logic [sgd_cfg_pkg::ADDR_W-1:0]     addr_b,
    input  logic [sgd_cfg_pkg::EPOCHS_W-1:0]   number_of_epochs,
    input  logic [sgd_cfg_pkg::SAMPLES_W-1:0]  number_of_samples,
    output logic [sgd_cfg_pkg::ADDR_W-1:0]     tx_rd_addr,
    output logic [sgd_cfg_pkg::TAG_W-1:0]      tx_rd_tag,
    output logic                               tx_rd_valid,
    input  logic                               tx_rd_ready
);
    import sgd_cfg_pkg::*;

    logic                  started;
    logic                  running;     // requests left to issue
    logic [EPOCHS_W-1:0]   epoch_cnt;
    logic [SAMPLES_W-1:0]  batch_cnt;
    logic [SAMPLES_W-1:0]  last_batch;
    logic [BATCH_BITS:0]   line_cnt;    // 0 is the label line, 1..8 the samples
    logic [BATCH_BITS-1:0] sample_lo;

    assign last_batch = (number_of_samples >> BATCH_BITS) - 1'b1;
    assign sample_lo  = line_cnt[BATCH_BITS-1:0] - 1'b1;  // line 8 wraps to 7
    assign tx_rd_valid = running;

    // label lines by batch, sample lines by sample index
    assign tx_rd_addr = (line_cnt == '0) ? addr_b + ADDR_W'(batch_cnt)
                                         : addr_a + ADDR_W'({batch_cnt, sample_lo});
    assign tx_rd_tag  = {line_cnt == '0, (TAG_W-1)'(line_cnt)};

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            started   <= 1'b0;
            running   <= 1'b0;
            epoch_cnt <= '0;
            batch_cnt <= '0;
            line_cnt  <= '0;
        end
        else if (start && !started)
        begin
            started <= 1'b1;
            running <= (number_of_epochs != '0) && (number_of_samples >= BATCH_SIZE);
        end
        else if (running && tx_rd_ready)    // request taken, step on
        begin
            if (line_cnt == (BATCH_BITS+1)'(BATCH_SIZE))
            begin
                line_cnt <= '0;
                if (batch_cnt == last_batch)
                begin
                    batch_cnt <= '0;
                    epoch_cnt <= epoch_cnt + 1'b1;
                    if (epoch_cnt == number_of_epochs - 1'b1)
                        running <= 1'b0;     // last epoch issued
                end
                else
                    batch_cnt <= batch_cnt + 1'b1;
            end
            else
                line_cnt <= line_cnt + 1'b1;
        end
    end

endmodule

/* host/sgd_dispatch.sv */
`timescale 1ns/1ps

module sgd_dispatch (
    input  logic                              clk,
    input  logic                              rst_n_g,
    input  logic [sgd_cfg_pkg::TAG_W-1:0]     rx_rd_tag,
    input  logic [sgd_cfg_pkg::LINE_W-1:0]    rx_rd_data,
    input  logic                              rx_rd_valid,
    output logic                              rx_rd_ready,
    output sgd_types_pkg::feature_line_t      sample_line,
    input  logic                              sample_rd,
    output logic                              sample_empty,
    output sgd_types_pkg::label_line_t        label_line,
    input  logic                              label_rd,
    output logic                              label_empty
);
    import sgd_cfg_pkg::*;
    import sgd_types_pkg::*;

    logic take;       // response accepted this cycle
    logic is_label;
    logic sample_af;
    logic label_af;

    assign take        = rx_rd_valid & rx_rd_ready;
    assign is_label    = rx_rd_tag[TAG_LABEL_BIT];
    assign rx_rd_ready = ~(sample_af | label_af);  // stall while either side is near full

    sgd_fifo #(.payload_t(feature_line_t)) u_sample_fifo (
        .clk(clk), .rst_n_g(rst_n_g),
        .wr_en(take & ~is_label), .din(feature_line_t'(rx_rd_data)),
        .almost_full(sample_af),
        .rd_en(sample_rd), .dout(sample_line), .empty(sample_empty)
    );

    sgd_fifo #(.payload_t(label_line_t)) u_label_fifo (
        .clk(clk), .rst_n_g(rst_n_g),
        .wr_en(take & is_label), .din(label_line_t'(rx_rd_data)),
        .almost_full(label_af),
        .rd_en(label_rd), .dout(label_line), .empty(label_empty)
    );

endmodule

/* compute/sgd_dot_product.sv */
`timescale 1ns/1ps

module sgd_dot_product (
    input  logic                               clk,
    input  logic                               rst_n_g,
    input  logic                               start,
    input  logic [sgd_cfg_pkg::EPOCHS_W-1:0]   number_of_epochs,
    input  logic [sgd_cfg_pkg::SAMPLES_W-1:0]  number_of_samples,
    input  sgd_types_pkg::feature_line_t       sample_line,
    output logic                               sample_rd,
    input  logic                               sample_empty,
    input  sgd_types_pkg::weight_vec_t         weights,
    input  logic                               x_committed,
    sample_if.src                              s
);
    import sgd_cfg_pkg::*;
    import sgd_types_pkg::*;

    localparam int PROD_W = FEATURE_W + WEIGHT_W;
    localparam int SUM_W  = PROD_W + $clog2(NUM_FEATURES);  // exact sum, no overflow

    logic                  started;
    logic                  wait_commit;  // batch popped, model not yet updated
    logic [BATCH_BITS-1:0] idx;          // sample within batch
    logic [SAMPLES_W-1:0]  batch_cnt;
    logic [SAMPLES_W-1:0]  last_batch;
    logic [EPOCHS_W-1:0]   epoch_cnt;
    logic                  batch_end;
    logic                  run_end;

    // stage 1 products
    logic                     v1;
    logic                     lib1;
    logic                     lor1;
    feature_line_t            feat1;
    logic signed [PROD_W-1:0] prod1 [NUM_FEATURES];
    logic signed [SUM_W-1:0]  sum;

    // weights already new in the x_committed cycle, so pop right away
    assign sample_rd  = started & ~sample_empty & (~wait_commit | x_committed);
    assign last_batch = (number_of_samples >> BATCH_BITS) - 1'b1;
    assign batch_end  = (idx == BATCH_BITS'(BATCH_SIZE - 1));
    assign run_end    = batch_end && (batch_cnt == last_batch)
                        && (epoch_cnt == number_of_epochs - 1'b1);

    ////////////////////////////////////////
    // sample, batch and epoch counts
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            started     <= 1'b0;
            wait_commit <= 1'b0;
            idx         <= '0;
            batch_cnt   <= '0;
            epoch_cnt   <= '0;
            v1          <= 1'b0;
            s.valid     <= 1'b0;
        end
        else
        begin
            v1      <= sample_rd;
            s.valid <= v1;
            if (start)
                started <= 1'b1;
            if (sample_rd)
                idx <= idx + 1'b1;
            if (sample_rd && batch_end)
            begin
                wait_commit <= 1'b1;   // hold off until the update lands
                if (batch_cnt == last_batch)
                begin
                    batch_cnt <= '0;
                    epoch_cnt <= epoch_cnt + 1'b1;
                end
                else
                    batch_cnt <= batch_cnt + 1'b1;
            end
            else if (x_committed)
                wait_commit <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // multiply, then add tree
    ////////////////////////////////////////
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < NUM_FEATURES; i++)
            sum = sum + prod1[i];
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_FEATURES; i++)
            prod1[i] <= sample_line[i] * weights[i];   // 16x32 signed
        feat1           <= sample_line;
        lib1            <= batch_end;
        lor1            <= run_end;
        s.features      <= feat1;
        s.dot           <= WEIGHT_W'(sum >>> FRAC_BITS);  // back to weight scale
        s.last_in_batch <= lib1;
        s.last_of_run   <= lor1;
    end

endmodule

/* compute/sgd_gradient.sv */
`timescale 1ns/1ps

module sgd_gradient (
    input  logic                             clk,
    input  logic                             rst_n_g,
    input  logic [sgd_cfg_pkg::STEP_W-1:0]   step_shift,
    input  sgd_types_pkg::label_line_t       label_line,
    output logic                             label_rd,
    input  logic                             label_empty,
    sample_if.dst                            s,
    update_if.src                            u
);
    import sgd_cfg_pkg::*;
    import sgd_types_pkg::*;

    localparam int PROD_W = FEATURE_W + WEIGHT_W;

    logic [BATCH_BITS-1:0] idx;       // picks this sample's label
    weight_t               diff;
    weight_t               loss;
    weight_vec_t           acc;       // running gradient of the batch
    weight_vec_t           acc_next;

    // head of the label FIFO is the current batch, freed after its last sample
    assign label_rd = s.valid & s.last_in_batch & ~label_empty;
    assign diff     = s.dot - label_line[idx];
    assign loss     = diff >>> step_shift;   // step size as a shift

    always_comb
    begin
        logic signed [PROD_W-1:0] prod;
        for (int i = 0; i < NUM_FEATURES; i++)
        begin
            prod        = s.features[i] * loss;
            acc_next[i] = acc[i] + WEIGHT_W'(prod >>> FRAC_BITS);  // wraps
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            idx     <= '0;
            acc     <= '0;
            u.valid <= 1'b0;
        end
        else
        begin
            u.valid <= s.valid & s.last_in_batch;
            if (s.valid)
            begin
                idx <= idx + 1'b1;
                acc <= s.last_in_batch ? '0 : acc_next;  // clear for next batch
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (s.valid && s.last_in_batch)
        begin
            u.grad        <= acc_next;
            u.last_of_run <= s.last_of_run;
        end
    end

endmodule

/* compute/sgd_model.sv */
`timescale 1ns/1ps

module sgd_model (
    input  logic                              clk,
    input  logic                              rst_n_g,
    input  logic [sgd_cfg_pkg::ADDR_W-1:0]    addr_model,
    update_if.dst                             u,
    output sgd_types_pkg::weight_vec_t        weights,
    output logic                              x_committed,
    output logic [sgd_cfg_pkg::ADDR_W-1:0]    tx_wr_addr,
    output logic [sgd_cfg_pkg::LINE_W-1:0]    tx_wr_data,
    output logic                              tx_wr_valid,
    input  logic                              tx_wr_ready,
    output logic                              done
);
    import sgd_cfg_pkg::*;
    import sgd_types_pkg::*;

    localparam int HALF = NUM_FEATURES / 2;   // weights per host line

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_LO,     // weights 0..3 to addr_model
        WB_HI,     // weights 4..7 to addr_model+1
        WB_DONE
    } wb_state_t;

    wb_state_t state;

    ////////////////////////////////////////
    // write-back channel, held until ready
    ////////////////////////////////////////
    assign tx_wr_valid = (state == WB_LO) || (state == WB_HI);
    assign tx_wr_addr  = addr_model + ADDR_W'(state == WB_HI);
    assign tx_wr_data  = (state == WB_HI) ? weights[NUM_FEATURES-1:HALF] : weights[HALF-1:0];
    assign done        = (state == WB_DONE);   // stays until reset

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            weights     <= '0;
            x_committed <= 1'b0;
            state       <= WB_IDLE;
        end
        else
        begin
            x_committed <= u.valid;   // weights and pulse land together
            if (u.valid)
            begin
                for (int i = 0; i < NUM_FEATURES; i++)
                    weights[i] <= weights[i] - u.grad[i];
            end
            case (state)
                WB_IDLE:
                    if (u.valid && u.last_of_run)
                        state <= WB_LO;
                WB_LO:
                    if (tx_wr_ready)
                        state <= WB_HI;
                WB_HI:
                    if (tx_wr_ready)
                        state <= WB_DONE;
                default:
                    state <= WB_DONE;
            endcase
        end
    end

endmodule

/* source/sgd_top.sv */
`timescale 1ns/1ps

module sgd_top (
    input  logic                               clk,
    input  logic                               rst_n_g,
    input  logic                               start,
    input  logic [sgd_cfg_pkg::PARAM_W-1:0]    params,
    output logic                               done,
    // read requests
    output logic [sgd_cfg_pkg::ADDR_W-1:0]     tx_rd_addr,
    output logic [sgd_cfg_pkg::TAG_W-1:0]      tx_rd_tag,
    output logic                               tx_rd_valid,
    input  logic                               tx_rd_ready,
    // read responses
    input  logic [sgd_cfg_pkg::TAG_W-1:0]      rx_rd_tag,
    input  logic [sgd_cfg_pkg::LINE_W-1:0]     rx_rd_data,
    input  logic                               rx_rd_valid,
    output logic                               rx_rd_ready,
    // model write-back
    output logic [sgd_cfg_pkg::ADDR_W-1:0]     tx_wr_addr,
    output logic [sgd_cfg_pkg::LINE_W-1:0]     tx_wr_data,
    output logic                               tx_wr_valid,
    input  logic                               tx_wr_ready
);
    import sgd_cfg_pkg::*;
    import sgd_types_pkg::*;

    ////////////////////////////////////////
    // parameter fields
    ////////////////////////////////////////
    logic [ADDR_W-1:0]    addr_a;
    logic [ADDR_W-1:0]    addr_b;
    logic [ADDR_W-1:0]    addr_model;
    logic [STEP_W-1:0]    step_shift;
    logic [EPOCHS_W-1:0]  number_of_epochs;
    logic [SAMPLES_W-1:0] number_of_samples;

    assign addr_a            = params[P_ADDR_A_LO +: ADDR_W];  // sample lines
    assign addr_b            = params[P_ADDR_B_LO +: ADDR_W];  // label lines
    assign addr_model        = params[P_ADDR_MODEL_LO +: ADDR_W];
    assign step_shift        = params[P_STEP_LO +: STEP_W];
    assign number_of_epochs  = params[P_EPOCHS_LO +: EPOCHS_W];
    assign number_of_samples = params[P_SAMPLES_LO +: SAMPLES_W];

    feature_line_t sample_line;
    logic          sample_rd;
    logic          sample_empty;
    label_line_t   label_line;
    logic          label_rd;
    logic          label_empty;
    weight_vec_t   weights;
    logic          x_committed;  // batch update landed

    sample_if smp ();
    update_if upd ();

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////
    sgd_mem_rd u_mem_rd (
        .clk(clk), .rst_n_g(rst_n_g), .start(start),
        .addr_a(addr_a), .addr_b(addr_b),
        .number_of_epochs(number_of_epochs), .number_of_samples(number_of_samples),
        .tx_rd_addr(tx_rd_addr), .tx_rd_tag(tx_rd_tag),
        .tx_rd_valid(tx_rd_valid), .tx_rd_ready(tx_rd_ready)
    );

    sgd_dispatch u_dispatch (
        .clk(clk), .rst_n_g(rst_n_g),
        .rx_rd_tag(rx_rd_tag), .rx_rd_data(rx_rd_data),
        .rx_rd_valid(rx_rd_valid), .rx_rd_ready(rx_rd_ready),
        .sample_line(sample_line), .sample_rd(sample_rd), .sample_empty(sample_empty),
        .label_line(label_line), .label_rd(label_rd), .label_empty(label_empty)
    );

    sgd_dot_product u_dot_product (
        .clk(clk), .rst_n_g(rst_n_g), .start(start),
        .number_of_epochs(number_of_epochs), .number_of_samples(number_of_samples),
        .sample_line(sample_line), .sample_rd(sample_rd), .sample_empty(sample_empty),
        .weights(weights), .x_committed(x_committed),
        .s(smp)
    );

    sgd_gradient u_gradient (
        .clk(clk), .rst_n_g(rst_n_g), .step_shift(step_shift),
        .label_line(label_line), .label_rd(label_rd), .label_empty(label_empty),
        .s(smp), .u(upd)
    );

    sgd_model u_model (
        .clk(clk), .rst_n_g(rst_n_g), .addr_model(addr_model),
        .u(upd), .weights(weights), .x_committed(x_committed),
        .tx_wr_addr(tx_wr_addr), .tx_wr_data(tx_wr_data),
        .tx_wr_valid(tx_wr_valid), .tx_wr_ready(tx_wr_ready),
        .done(done)
    );

endmodule

/* verification/sgd_tb_assert.sv */
`timescale 1ns/1ps

// bound into sgd_top
module sgd_tb_assert (
    input logic                            clk,
    input logic                            rst_n_g,
    input logic                            tx_wr_valid,
    input logic                            tx_wr_ready,
    input logic [sgd_cfg_pkg::ADDR_W-1:0]  tx_wr_addr,
    input logic [sgd_cfg_pkg::LINE_W-1:0]  tx_wr_data,
    input logic                            done,
    input logic [sgd_cfg_pkg::TAG_W-1:0]   rx_rd_tag,
    input logic                            rx_rd_valid,
    input logic                            rx_rd_ready,
    input logic                            sample_rd,
    input logic                            sample_empty,
    input logic                            label_rd,
    input logic                            label_empty
);
    import sgd_cfg_pkg::*;

    localparam int OCC_W     = FIFO_DEPTH_BITS + 1;
    localparam int NEAR_FULL = (1 << FIFO_DEPTH_BITS) - FIFO_SLACK;

    logic             rsp_take;
    logic [OCC_W-1:0] sample_occ;   // lines held, counted from the handshakes
    logic [OCC_W-1:0] label_occ;

    assign rsp_take = rx_rd_valid & rx_rd_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            sample_occ <= '0;
            label_occ  <= '0;
        end
        else
        begin
            sample_occ <= sample_occ + OCC_W'(rsp_take & ~rx_rd_tag[TAG_LABEL_BIT])
                          - OCC_W'(sample_rd & ~sample_empty);
            label_occ  <= label_occ + OCC_W'(rsp_take & rx_rd_tag[TAG_LABEL_BIT])
                          - OCC_W'(label_rd & ~label_empty);
        end
    end

    // write request held until the host takes it
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n_g)
        tx_wr_valid && !tx_wr_ready |=> tx_wr_valid && $stable(tx_wr_addr) && $stable(tx_wr_data))
        else $error("write-back changed before ready");

    // done is sticky until reset
    a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n_g)
        done |=> done)
        else $error("done fell without reset");

    a_rx_ready: assert property (@(posedge clk) disable iff (!rst_n_g)
        !rx_rd_ready |-> (sample_occ >= NEAR_FULL) || (label_occ >= NEAR_FULL))  // near full only
        else $error("response channel stalled with room in both FIFOs");

endmodule

bind sgd_top sgd_tb_assert i_assert (
    .clk(clk), .rst_n_g(rst_n_g),
    .tx_wr_valid(tx_wr_valid), .tx_wr_ready(tx_wr_ready),
    .tx_wr_addr(tx_wr_addr), .tx_wr_data(tx_wr_data),
    .done(done),
    .rx_rd_tag(rx_rd_tag), .rx_rd_valid(rx_rd_valid), .rx_rd_ready(rx_rd_ready),
    .sample_rd(sample_rd), .sample_empty(sample_empty),
    .label_rd(label_rd), .label_empty(label_empty)
);

/* verification/sgd_tb.sv */
`timescale 1ns/1ps

module sgd_tb;
    import sgd_cfg_pkg::*;

    localparam logic [57:0] A_BASE = 58'h1000;   // sample lines
    localparam logic [57:0] B_BASE = 58'h2000;   // label lines
    localparam logic [57:0] M_BASE = 58'h3000;   // model

    logic clk, rst_n_g, start, done;
    logic [PARAM_W-1:0] params;
    logic [ADDR_W-1:0] tx_rd_addr, tx_wr_addr;
    logic [TAG_W-1:0]  tx_rd_tag, rx_rd_tag;
    logic tx_rd_valid, tx_rd_ready, rx_rd_valid, rx_rd_ready, tx_wr_valid, tx_wr_ready;
    logic [LINE_W-1:0] rx_rd_data, tx_wr_data;

    logic [LINE_W-1:0] sample_mem [24];
    logic [LINE_W-1:0] label_mem [3];
    logic [15:0]  lfsr = 16'd80;
    logic [ADDR_W+TAG_W-1:0] req_q [$];         // {addr, tag} in issue order
    logic [LINE_W-1:0] wr_data [2];
    logic [ADDR_W-1:0] wr_addr [2];
    int   wr_count, req_idx, n_batch, n_epoch, mode, delay, cyc, cyc_base, limit;
    logic rsp_taken;

    sgd_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////
    // helpers
    //////////////////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;   // one step per bit
        end
        return r;
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // replays the update rules over every batch of every epoch
    function automatic logic [255:0] ref_model(input int epochs, input int nb, input int step);
        logic signed [31:0] w [8];
        logic signed [31:0] g [8];
        logic signed [31:0] dot, diff, loss;
        logic signed [15:0] f, lab;
        logic signed [63:0] acc, p;
        logic [255:0] res;
        for (int i = 0; i < 8; i++)
            w[i] = '0;
        for (int e = 0; e < epochs; e++)
            for (int b = 0; b < nb; b++)
            begin
                for (int i = 0; i < 8; i++)
                    g[i] = '0;
                for (int k = 0; k < 8; k++)
                begin
                    acc = '0;
                    for (int i = 0; i < 8; i++)
                    begin
                        f = sample_mem[b*8+k][16*i +: 16];
                        acc = acc + f * w[i];
                    end
                    dot  = acc >>> FRAC_BITS;
                    lab  = label_mem[b][16*k +: 16];
                    diff = dot - lab;
                    loss = diff >>> step;
                    for (int i = 0; i < 8; i++)
                    begin
                        f = sample_mem[b*8+k][16*i +: 16];
                        p = f * loss;
                        g[i] = g[i] + (p >>> FRAC_BITS);   // wraps at 32 bits
                    end
                end
                for (int i = 0; i < 8; i++)
                    w[i] = w[i] - g[i];
            end
        for (int i = 0; i < 8; i++)
            res[32*i +: 32] = w[i];
        return res;
    endfunction

    task automatic fill_memory();
        logic signed [15:0] h [8];
        int lab;
        for (int i = 0; i < 8; i++)
            h[i] = $signed(rand_bits(3) << 29) >>> 29;   // hidden weights, -4..3
        for (int n = 0; n < 24; n++)
        begin
            lab = $signed(rand_bits(4) << 28) >>> 28;   // small noise
            for (int i = 0; i < 8; i++)
            begin
                sample_mem[n][16*i +: 16] = $signed(rand_bits(8) << 24) >>> 24;
                lab += $signed(sample_mem[n][16*i +: 16]) * h[i];
            end
            label_mem[n/8][16*(n%8) +: 16] = 16'(lab);
        end
    endtask

    function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] a);
        if (a >= A_BASE && a < A_BASE + 24)
            return sample_mem[a - A_BASE];
        if (a >= B_BASE && a < B_BASE + 3)
            return label_mem[a - B_BASE];
        return '0;
    endfunction

    //////////////////////////////////////////
    // host side
    //////////////////////////////////////////
    always @(posedge clk)
    begin
        cyc++;
        rsp_taken = rst_n_g && rx_rd_valid && rx_rd_ready;
        if (rst_n_g && tx_rd_valid && tx_rd_ready)
        begin
            // label line of the batch, then its 8 sample lines
            if (req_idx >= n_epoch * n_batch * 9)
                check("extra read request", 1'b1, 1'b0);
            if (req_idx % 9 == 0)
            begin
                check("label addr", tx_rd_addr, B_BASE + (req_idx / 9) % n_batch);
                check("label tag", tx_rd_tag, 8'h80);
            end
            else
            begin
                check("sample addr", tx_rd_addr,
                      A_BASE + ((req_idx / 9) % n_batch) * 8 + req_idx % 9 - 1);
                check("sample tag", tx_rd_tag, req_idx % 9);
            end
            req_q.push_back({tx_rd_addr, tx_rd_tag});
            req_idx++;
        end
        if (rst_n_g && tx_wr_valid && tx_wr_ready)
        begin
            if (wr_count < 2)
            begin
                wr_addr[wr_count] = tx_wr_addr;
                wr_data[wr_count] = tx_wr_data;
            end
            wr_count++;
        end
        if (limit > 0 && cyc - cyc_base > limit)
        begin
            $display("timeout: done did not rise within %0d cycles", limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk)
    begin
        if (rsp_taken)
        begin
            void'(req_q.pop_front());
            rx_rd_valid = 1'b0;
            delay = (mode == 1) ? rand_bits(2) : 0;   // gap before next response
        end
        if (!rx_rd_valid && req_q.size() > 0)
        begin
            if (delay == 0)
            begin
                rx_rd_valid = 1'b1;
                rx_rd_tag   = req_q[0][TAG_W-1:0];
                rx_rd_data  = line_at(req_q[0][ADDR_W+TAG_W-1:TAG_W]);
            end
            else
                delay--;
        end
        case (mode)
            1: tx_rd_ready = rand_bits(1);
            2: tx_rd_ready = !(cyc - cyc_base >= 10 && cyc - cyc_base < 90);  // long stall
            default: tx_rd_ready = 1'b1;
        endcase
        tx_wr_ready = (mode == 1) ? rand_bits(1) : 1'b1;
    end

    //////////////////////////////////////////
    // test cases
    //////////////////////////////////////////
    task automatic run_case(input int epochs, input int nsamp, input int step, input int m);
        logic [255:0] exp;
        @(negedge clk);
        rst_n_g = 1'b0;
        n_epoch = epochs;
        n_batch = nsamp / 8;
        req_idx = 0;
        wr_count = 0;
        params = '0;
        params[57:0]    = A_BASE;
        params[121:64]  = B_BASE;
        params[185:128] = M_BASE;
        params[196:192] = 5'(step);
        params[223:208] = 16'(epochs);
        params[255:224] = 32'(nsamp);
        repeat (2) @(negedge clk);
        rst_n_g = 1'b1;
        mode = m;
        repeat (3)
        begin
            @(negedge clk);
            check("idle outputs", {tx_rd_valid, tx_wr_valid, done}, 3'b000);
        end
        exp = ref_model(epochs, n_batch, step);
        cyc_base = cyc;
        limit = 20 * epochs * n_batch * 9 + 200;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        limit = 0;
        check("request count", req_idx, epochs * n_batch * 9);
        check("low half addr", wr_addr[0], M_BASE);
        check("low half data", wr_data[0], exp[127:0]);
        check("high half addr", wr_addr[1], M_BASE + 1);
        check("high half data", wr_data[1], exp[255:128]);
        repeat (10) @(negedge clk);
        check("done held", done, 1'b1);
        check("write count", wr_count, 2);
    endtask

    initial
    begin
        rst_n_g = 1'b0;
        start = 1'b0;
        params = '0;
        tx_rd_ready = 1'b0;
        tx_wr_ready = 1'b0;
        rx_rd_valid = 1'b0;
        rx_rd_tag = '0;
        rx_rd_data = '0;
        rsp_taken = 1'b0;
        mode = 0;
        delay = 0;
        cyc = 0;
        cyc_base = 0;
        limit = 0;
        n_epoch = 1;
        n_batch = 1;
        fill_memory();
        run_case(1, 8, 4, 0);    // single batch
        run_case(3, 24, 4, 1);   // random ready and delays
        run_case(3, 24, 4, 2);   // stalled request channel
        $display("TEST PASS");
        $finish;
    end

endmodule

/* sgd_top.f */
common/sgd_cfg_pkg.sv
common/sgd_types_pkg.sv
common/sgd_stream_if.sv
source/sgd_fifo.sv
host/sgd_mem_rd.sv
host/sgd_dispatch.sv
compute/sgd_dot_product.sv
compute/sgd_gradient.sv
compute/sgd_model.sv
source/sgd_top.sv
verification/sgd_tb_assert.sv
verification/sgd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -sv --assert --timing -f sgd_top.f --top-module sgd_tb -o sgd_sim

./obj_dir/sgd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
